/* snow_params.svh */
`ifndef SNOW_PARAMS_SVH
`define SNOW_PARAMS_SVH

// Data path
`define SNOW_WORD_W 32

// 512-word shared memory
`define SNOW_ADDR_W 9

// Block transfers move at most 63 words
`define SNOW_CNT_W 6

// Device sections
`define SNOW_SECTIONS 4
`define SNOW_DEPTH 16

`endif

/* snow_pkg.sv */
`default_nettype none
`include "snow_params.svh"

package snow_pkg;

  typedef logic [`SNOW_WORD_W-1:0]            word_t;
  typedef logic [`SNOW_ADDR_W-1:0]            addr_t;
  typedef logic [`SNOW_CNT_W-1:0]             count_t;
  typedef logic [$clog2(`SNOW_SECTIONS)-1:0]  section_t;

  typedef struct packed {
    logic  mark;                                 // Stops a fill early
    word_t data;
  } in_entry_t;

  typedef struct packed {
    logic     dir;                               // 0 fill, 1 empty
    section_t section;
    addr_t    addr;
    count_t   count;
  } blk_cmd_t;

  typedef struct packed {
    logic  req;
    logic  we;
    addr_t addr;
    word_t wdata;
  } mem_req_t;

  typedef struct packed {
    logic  req;
    logic  we;
    addr_t addr;
    word_t wdata;
  } host_req_t;

endpackage

`default_nettype wire

/* section_buffer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "snow_params.svh"

module section_buffer
  import snow_pkg::*;
#(
  parameter type T = word_t
) (
  input  wire                        i_clk_n,
  input  wire                        i_rst_master,
  input  wire  [`SNOW_SECTIONS-1:0]  i_push,
  input  wire  T                     i_push_data [`SNOW_SECTIONS],
  input  wire  [`SNOW_SECTIONS-1:0]  i_pop,
  output T                           o_head [`SNOW_SECTIONS],
  output logic [`SNOW_SECTIONS-1:0]  o_empty,
  output logic [`SNOW_SECTIONS-1:0]  o_full
);

  localparam int ptr_w = $clog2(`SNOW_DEPTH);
  localparam int occ_w = ptr_w + 1;

  for (genvar s = 0; s < `SNOW_SECTIONS; s++)
  begin : g_section
    T                 mem [`SNOW_DEPTH];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [occ_w-1:0] occ;
    logic             do_push;
    logic             do_pop;

    assign o_empty[s] = (occ == '0);
    assign o_full[s]  = (occ == occ_w'(`SNOW_DEPTH));
    assign do_push    = i_push[s] && !o_full[s];  // Full section drops the word
    assign do_pop     = i_pop[s] && !o_empty[s];
    assign o_head[s]  = mem[rd_ptr];              // Show-ahead head

    always_ff @(posedge i_clk_n)
    begin
      if (do_push)
        mem[wr_ptr] <= i_push_data[s];
    end

    always_ff @(posedge i_clk_n)
    begin
      if (i_rst_master)
      begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        occ    <= '0;
      end
      else
      begin
        if (do_push)
          wr_ptr <= wr_ptr + 1'b1;
        if (do_pop)
          rd_ptr <= rd_ptr + 1'b1;
        if (do_push && !do_pop)
          occ <= occ + 1'b1;
        else if (do_pop && !do_push)
          occ <= occ - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* shared_memory.sv */
`timescale 1ns/1ps
`default_nettype none
`include "snow_params.svh"

module shared_memory
  import snow_pkg::*;
(
  input  wire             i_clk_n,
  input  wire             i_rst_master,
  input  wire  mem_req_t  i_req [3],
  output logic [2:0]      o_grant,
  output word_t           o_rdata,
  output logic [2:0]      o_rvalid,
  output logic            o_host_wack
);

  localparam int n_req = 3;

  word_t    mem [2**`SNOW_ADDR_W];
  mem_req_t sel;

  // ------------------------------------------------------------------------
  // Fixed priority, index 0 (host) wins
  // ------------------------------------------------------------------------
  always_comb
  begin
    o_grant = '0;
    sel     = '0;
    for (int i = n_req - 1; i >= 0; i--)
    begin
      if (i_req[i].req)
      begin
        o_grant    = '0;
        o_grant[i] = 1'b1;
        sel        = i_req[i];
      end
    end
  end

  // ------------------------------------------------------------------------
  // Memory array
  // ------------------------------------------------------------------------
  always_ff @(posedge i_clk_n)
  begin
    if (sel.req && sel.we)
      mem[sel.addr] <= sel.wdata;
    if (sel.req && !sel.we)
      o_rdata <= mem[sel.addr];               // Registered read
  end

  always_ff @(posedge i_clk_n)
  begin
    if (i_rst_master)
    begin
      o_rvalid    <= '0;
      o_host_wack <= 1'b0;
    end
    else
    begin
      o_rvalid    <= sel.we ? '0 : o_grant;   // Owner of the read data
      o_host_wack <= o_grant[0] && sel.we;
    end
  end

endmodule

`default_nettype wire

/* fill_mover.sv */
`timescale 1ns/1ps
`default_nettype none
`include "snow_params.svh"

module fill_mover
  import snow_pkg::*;
(
  input  wire                        i_clk_n,
  input  wire                        i_rst_master,
  input  wire                        i_cmd_valid,
  input  wire  blk_cmd_t             i_cmd,
  input  wire  in_entry_t            i_head [`SNOW_SECTIONS],
  input  wire  [`SNOW_SECTIONS-1:0]  i_empty,
  input  wire                        i_grant,
  output logic [`SNOW_SECTIONS-1:0]  o_pop,
  output mem_req_t                   o_req,
  output logic                       o_busy,
  output logic                       o_done,
  output count_t                     o_sent
);

  section_t  sec_q;
  count_t    cnt_q;
  addr_t     addr_q;
  in_entry_t head;
  logic      wr_go;
  logic      last;

  assign head  = i_head[sec_q];
  assign o_req = '{req: o_busy && !i_empty[sec_q], we: 1'b1, addr: addr_q, wdata: head.data};
  assign wr_go = o_req.req && i_grant;
  assign last  = head.mark || (count_t'(o_sent + 1'b1) == cnt_q);

  always_comb
  begin
    o_pop        = '0;
    o_pop[sec_q] = wr_go;                     // Pop on the write edge
  end

  always_ff @(posedge i_clk_n)
  begin
    if (i_cmd_valid && !i_cmd.dir)
    begin
      sec_q  <= i_cmd.section;
      cnt_q  <= i_cmd.count;
      addr_q <= i_cmd.addr;
    end
    else if (wr_go)
      addr_q <= addr_q + 1'b1;
  end

  always_ff @(posedge i_clk_n)
  begin
    if (i_rst_master)
    begin
      o_busy <= 1'b0;
      o_done <= 1'b0;
      o_sent <= '0;
    end
    else
    begin
      o_done <= 1'b0;
      if (i_cmd_valid)
      begin
        o_sent <= '0;                         // Shared sent bus, clear on any command
        if (!i_cmd.dir)
        begin
          o_busy <= (i_cmd.count != '0);
          o_done <= (i_cmd.count == '0);
        end
      end
      else if (wr_go)
      begin
        o_sent <= o_sent + 1'b1;
        if (last)
        begin
          o_busy <= 1'b0;
          o_done <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* empty_mover.sv */
`timescale 1ns/1ps
`default_nettype none
`include "snow_params.svh"

module empty_mover
  import snow_pkg::*;
(
  input  wire                        i_clk_n,
  input  wire                        i_rst_master,
  input  wire                        i_cmd_valid,
  input  wire  blk_cmd_t             i_cmd,
  input  wire  [`SNOW_SECTIONS-1:0]  i_full,
  input  wire                        i_grant,
  input  wire  word_t                i_rdata,
  input  wire                        i_rvalid,
  output mem_req_t                   o_req,
  output logic [`SNOW_SECTIONS-1:0]  o_push,
  output logic                       o_busy,
  output logic                       o_done,
  output count_t                     o_sent
);

  section_t sec_q;
  count_t   cnt_q;
  addr_t    addr_q;
  logic     pend_q;                           // One read in flight
  logic     rd_go;
  logic     take;

  assign o_req = '{req: o_busy && !pend_q && !i_full[sec_q], we: 1'b0, addr: addr_q,
                   wdata: '0};
  assign rd_go = o_req.req && i_grant;
  assign take  = o_busy && pend_q && i_rvalid;

  always_comb
  begin
    o_push        = '0;
    o_push[sec_q] = take;                     // Word lands the edge it is valid
  end

  always_ff @(posedge i_clk_n)
  begin
    if (i_cmd_valid && i_cmd.dir)
    begin
      sec_q  <= i_cmd.section;
      cnt_q  <= i_cmd.count;
      addr_q <= i_cmd.addr;
    end
    else if (rd_go)
      addr_q <= addr_q + 1'b1;
  end

  always_ff @(posedge i_clk_n)
  begin
    if (i_rst_master)
    begin
      o_busy <= 1'b0;
      o_done <= 1'b0;
      o_sent <= '0;
      pend_q <= 1'b0;
    end
    else
    begin
      o_done <= 1'b0;
      if (i_cmd_valid)
      begin
        o_sent <= '0;
        pend_q <= 1'b0;
        if (i_cmd.dir)
        begin
          o_busy <= (i_cmd.count != '0);
          o_done <= (i_cmd.count == '0);
        end
      end
      else if (rd_go)
        pend_q <= 1'b1;
      else if (take)
      begin
        pend_q <= 1'b0;
        o_sent <= o_sent + 1'b1;
        if (count_t'(o_sent + 1'b1) == cnt_q)
        begin
          o_busy <= 1'b0;
          o_done <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* snow_core.sv */
`timescale 1ns/1ps
`default_nettype none
`include "snow_params.svh"

module snow_core
  import snow_pkg::*;
(
  input  wire                        i_clk_n,
  input  wire                        i_rst_master,
  input  wire  [`SNOW_SECTIONS-1:0]  i_dev_wr,
  input  wire  word_t                i_dev_data [`SNOW_SECTIONS],
  input  wire  [`SNOW_SECTIONS-1:0]  i_dev_mark,
  input  wire  [`SNOW_SECTIONS-1:0]  i_dev_rd,
  input  wire                        i_cmd_valid,
  input  wire  blk_cmd_t             i_cmd,
  input  wire  host_req_t            i_host_req,
  output logic [`SNOW_SECTIONS-1:0]  o_in_full,
  output word_t                      o_out_data [`SNOW_SECTIONS],
  output logic [`SNOW_SECTIONS-1:0]  o_out_empty,
  output logic                       o_busy,
  output logic                       o_done,
  output count_t                     o_sent,
  output logic                       o_host_ack,
  output word_t                      o_host_rdata
);

  in_entry_t                 in_push_data [`SNOW_SECTIONS];
  in_entry_t                 in_head [`SNOW_SECTIONS];
  logic [`SNOW_SECTIONS-1:0] in_empty;
  logic [`SNOW_SECTIONS-1:0] in_pop;
  word_t                     out_push_data [`SNOW_SECTIONS];
  logic [`SNOW_SECTIONS-1:0] out_push;
  logic [`SNOW_SECTIONS-1:0] out_full;
  mem_req_t                  host_mem_req;
  mem_req_t                  fill_req;
  mem_req_t                  empty_req;
  mem_req_t                  mem_req [3];
  logic [2:0]                mem_grant;
  logic [2:0]                mem_rvalid;
  word_t                     mem_rdata;
  logic                      host_wack;
  logic                      fill_busy;
  logic                      fill_done;
  count_t                    fill_sent;
  logic                      empty_busy;
  logic                      empty_done;
  count_t                    empty_sent;

  for (genvar s = 0; s < `SNOW_SECTIONS; s++)
  begin : g_lane
    assign in_push_data[s]  = '{mark: i_dev_mark[s], data: i_dev_data[s]};
    assign out_push_data[s] = mem_rdata;      // Read data fans out to every section
  end

  assign host_mem_req = '{req: i_host_req.req, we: i_host_req.we,
                          addr: i_host_req.addr, wdata: i_host_req.wdata};
  assign mem_req      = '{host_mem_req, fill_req, empty_req};

  // Movers never run together
  assign o_busy       = fill_busy | empty_busy;
  assign o_done       = fill_done | empty_done;
  assign o_sent       = fill_sent | empty_sent;
  assign o_host_ack   = mem_rvalid[0] | host_wack;
  assign o_host_rdata = mem_rdata;

  // ------------------------------------------------------------------------
  // Inbound path
  // ------------------------------------------------------------------------
  section_buffer #(.T(in_entry_t)) in_buf_inst (
    .i_clk_n(i_clk_n), .i_rst_master(i_rst_master),
    .i_push(i_dev_wr), .i_push_data(in_push_data), .i_pop(in_pop),
    .o_head(in_head), .o_empty(in_empty), .o_full(o_in_full)
  );

  fill_mover fill_inst (
    .i_clk_n(i_clk_n), .i_rst_master(i_rst_master),
    .i_cmd_valid(i_cmd_valid), .i_cmd(i_cmd),
    .i_head(in_head), .i_empty(in_empty), .i_grant(mem_grant[1]),
    .o_pop(in_pop), .o_req(fill_req),
    .o_busy(fill_busy), .o_done(fill_done), .o_sent(fill_sent)
  );

  // ------------------------------------------------------------------------
  // Shared memory
  // ------------------------------------------------------------------------
  shared_memory mem_inst (
    .i_clk_n(i_clk_n), .i_rst_master(i_rst_master),
    .i_req(mem_req), .o_grant(mem_grant), .o_rdata(mem_rdata),
    .o_rvalid(mem_rvalid), .o_host_wack(host_wack)
  );

  // ------------------------------------------------------------------------
  // Outbound path
  // ------------------------------------------------------------------------
  empty_mover empty_inst (
    .i_clk_n(i_clk_n), .i_rst_master(i_rst_master),
    .i_cmd_valid(i_cmd_valid), .i_cmd(i_cmd), .i_full(out_full),
    .i_grant(mem_grant[2]), .i_rdata(mem_rdata), .i_rvalid(mem_rvalid[2]),
    .o_req(empty_req), .o_push(out_push),
    .o_busy(empty_busy), .o_done(empty_done), .o_sent(empty_sent)
  );

  section_buffer #(.T(word_t)) out_buf_inst (
    .i_clk_n(i_clk_n), .i_rst_master(i_rst_master),
    .i_push(out_push), .i_push_data(out_push_data), .i_pop(i_dev_rd),
    .o_head(o_out_data), .o_empty(o_out_empty), .o_full(out_full)
  );

endmodule

`default_nettype wire

/* snow_checker.sv */
`timescale 1ns/1ps
`default_nettype none
`include "snow_params.svh"

module snow_checker
  import snow_pkg::*;
(
  input  wire                        i_clk_n,
  input  wire                        i_rst_master,
  input  wire  [`SNOW_SECTIONS-1:0]  i_dev_wr,
  input  wire  word_t                i_dev_data [`SNOW_SECTIONS],
  input  wire  [`SNOW_SECTIONS-1:0]  i_dev_mark,
  input  wire  [`SNOW_SECTIONS-1:0]  i_dev_rd,
  input  wire                        i_cmd_valid,
  input  wire  blk_cmd_t             i_cmd,
  input  wire  host_req_t            i_host_req,
  input  wire  [`SNOW_SECTIONS-1:0]  i_in_full,
  input  wire  word_t                i_out_data [`SNOW_SECTIONS],
  input  wire  [`SNOW_SECTIONS-1:0]  i_out_empty,
  input  wire                        i_busy,
  input  wire                        i_done,
  input  wire  count_t               i_sent,
  input  wire                        i_host_ack,
  input  wire  word_t                i_host_rdata
);

  localparam int depth     = `SNOW_DEPTH;
  localparam int mem_words = 2**`SNOW_ADDR_W;

  word_t     mem_model [mem_words];
  logic      mem_valid [mem_words];               // Written at least once
  in_entry_t in_q [`SNOW_SECTIONS][$];
  word_t     out_q [`SNOW_SECTIONS][$];
  logic      rst_q;
  logic      host_pend;
  logic      host_pend_we;
  logic      host_pend_ok;
  word_t     host_pend_data;
  logic      done_pend;
  count_t    done_sent;
  int        errors;
  int        checks;
  int        tests;
  int        tests_passed;
  int        test_errors;

  initial
  begin
    for (int a = 0; a < mem_words; a++)
      mem_valid[a] = 1'b0;
    rst_q     = 1'b1;
    host_pend = 1'b0;
    done_pend = 1'b0;
    done_sent = '0;
  end

  task automatic report_failure(input string msg);
    errors++;
    test_errors++;
    $display("error at %0t: %s", $time, msg);
  endtask

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] got);
    checks++;
    if (exp !== got)
    begin
      errors++;
      test_errors++;
      $display("mismatch at %0t: %s expected %0h got %0h", $time, name, exp, got);
    end
  endtask

  task automatic end_test(input string name);
    if (done_pend)
      report_failure("a block transfer was still running at the end of the test");
    tests++;
    if (test_errors == 0)
      tests_passed++;
    $display("test %-10s finished with %0d errors", name, test_errors);
    test_errors = 0;
  endtask

  task automatic summary();
    $display("tests %0d, passed %0d, checks %0d, errors %0d",
             tests, tests_passed, checks, errors);
  endtask

  task automatic check_drained(input int s);
    if (out_q[s].size() != 0)
      report_failure($sformatf("outbound section %0d lost %0d words", s, out_q[s].size()));
    check_value($sformatf("o_out_empty[%0d]", s), 1, i_out_empty[s]);
  endtask

  // --------------------------------------------------------------------------
  // Per-edge checks, all on values from before the edge
  // --------------------------------------------------------------------------
  task automatic check_reset();
    check_value("o_busy", 0, i_busy);
    check_value("o_done", 0, i_done);
    check_value("o_host_ack", 0, i_host_ack);
    check_value("o_out_empty", 4'hf, i_out_empty);
    check_value("o_in_full", 0, i_in_full);
    check_value("o_sent", 0, i_sent);
  endtask

  task automatic check_host();
    check_value("o_host_ack", host_pend, i_host_ack);
    if (host_pend && !host_pend_we && host_pend_ok)
      check_value("o_host_rdata", host_pend_data, i_host_rdata);
    host_pend      = i_host_req.req;
    host_pend_we   = i_host_req.we;
    host_pend_data = mem_model[i_host_req.addr];  // Value before this edge
    host_pend_ok   = mem_valid[i_host_req.addr];
    if (i_host_req.req && i_host_req.we)
    begin
      mem_model[i_host_req.addr] = i_host_req.wdata;
      mem_valid[i_host_req.addr] = 1'b1;
    end
  endtask

  task automatic check_movers();
    word_t exp;
    check_value("o_busy", done_pend && !i_done, i_busy);  // High until the done pulse
    if (i_done)
    begin
      if (!done_pend)
        report_failure("done pulse with no block transfer running");
      else
        check_value("o_sent", done_sent, i_sent);
      done_pend = 1'b0;
    end
    for (int s = 0; s < `SNOW_SECTIONS; s++)
    begin
      if (!i_busy)                                // Pops settle once idle
        check_value($sformatf("o_in_full[%0d]", s), in_q[s].size() == depth, i_in_full[s]);
      if (i_dev_rd[s] && !i_out_empty[s])
      begin
        if (out_q[s].size() == 0)
          report_failure($sformatf("outbound section %0d gave an extra word", s));
        else
        begin
          exp = out_q[s].pop_front();
          check_value($sformatf("o_out_data[%0d]", s), exp, i_out_data[s]);
        end
      end
    end
  endtask

  task automatic apply_inputs();
    in_entry_t e;
    addr_t     a;
    int        n;
    for (int s = 0; s < `SNOW_SECTIONS; s++)
      if (i_dev_wr[s] && in_q[s].size() < depth)  // Full section drops it
      begin
        e = '{mark: i_dev_mark[s], data: i_dev_data[s]};
        in_q[s].push_back(e);
      end
    if (i_cmd_valid)
    begin
      done_pend = 1'b1;
      n = 0;
      for (int i = 0; i < int'(i_cmd.count); i++)
      begin
        a = addr_t'(i_cmd.addr + i);
        if (!i_cmd.dir)
        begin
          if (in_q[i_cmd.section].size() == 0)
          begin
            report_failure("fill command asks for more words than were supplied");
            break;
          end
          e = in_q[i_cmd.section].pop_front();
          mem_model[a] = e.data;
          mem_valid[a] = 1'b1;
          n++;
          if (e.mark)
            break;
        end
        else
        begin
          if (!mem_valid[a])
            report_failure("empty command reads a word that was never written");
          out_q[i_cmd.section].push_back(mem_model[a]);
          n++;
        end
      end
      done_sent = count_t'(n);
    end
  endtask

  always @(posedge i_clk_n)
  begin
    rst_q <= i_rst_master;
    if (!i_rst_master)
    begin
      if (rst_q)
        check_reset();
      check_host();
      check_movers();
      apply_inputs();
    end
  end

endmodule

`default_nettype wire

/* tb_snow_core.sv */
`timescale 1ns/1ps
`default_nettype none
`include "snow_params.svh"

module tb_snow_core
  import snow_pkg::*;
();

  localparam int     n_host   = 200;
  localparam int     n_fill   = 24;
  localparam int     n_empty  = 16;
  localparam int     n_mixed  = 24;
  localparam int     op_limit = 400;              // Cycles allowed per transfer
  localparam longint wd_cycles = 10 + n_host + 200 + (n_fill + n_empty + n_mixed) * 2 * op_limit;
  localparam longint wd_ns    = wd_cycles * 40 * 2;

  logic                      CLK_n;
  logic                      RST_MASTER;
  logic [`SNOW_SECTIONS-1:0] dev_wr;
  word_t                     dev_data [`SNOW_SECTIONS];
  logic [`SNOW_SECTIONS-1:0] dev_mark;
  logic [`SNOW_SECTIONS-1:0] dev_rd;
  logic                      cmd_valid;
  blk_cmd_t                  cmd;
  host_req_t                 host_req;
  logic [`SNOW_SECTIONS-1:0] in_full;
  word_t                     out_data [`SNOW_SECTIONS];
  logic [`SNOW_SECTIONS-1:0] out_empty;
  logic                      busy;
  logic                      done;
  count_t                    sent;
  logic                      host_ack;
  word_t                     host_rdata;
  logic                      contention;
  int                        rd_sec;              // Section being read out, -1 for none

  initial
  begin
    CLK_n = 1'b0;
    forever #20 CLK_n = ~CLK_n;
  end

  snow_core snow_core_inst (
    .i_clk_n(CLK_n), .i_rst_master(RST_MASTER),
    .i_dev_wr(dev_wr), .i_dev_data(dev_data), .i_dev_mark(dev_mark), .i_dev_rd(dev_rd),
    .i_cmd_valid(cmd_valid), .i_cmd(cmd), .i_host_req(host_req),
    .o_in_full(in_full), .o_out_data(out_data), .o_out_empty(out_empty),
    .o_busy(busy), .o_done(done), .o_sent(sent),
    .o_host_ack(host_ack), .o_host_rdata(host_rdata)
  );

  snow_checker check_inst (
    .i_clk_n(CLK_n), .i_rst_master(RST_MASTER),
    .i_dev_wr(dev_wr), .i_dev_data(dev_data), .i_dev_mark(dev_mark), .i_dev_rd(dev_rd),
    .i_cmd_valid(cmd_valid), .i_cmd(cmd), .i_host_req(host_req),
    .i_in_full(in_full), .i_out_data(out_data), .i_out_empty(out_empty),
    .i_busy(busy), .i_done(done), .i_sent(sent),
    .i_host_ack(host_ack), .i_host_rdata(host_rdata)
  );

  // --------------------------------------------------------------------------
  // Stimulus, always applied on the falling edge
  // --------------------------------------------------------------------------
  task automatic next_cycle();
    @(negedge CLK_n);
    dev_wr    = '0;
    dev_mark  = '0;
    dev_rd    = '0;
    cmd_valid = 1'b0;
    host_req  = '0;
    if (contention && ($urandom % 2 == 0))        // Host stays in the upper half
      host_req = '{req: 1'b1, we: 1'($urandom % 2), addr: addr_t'(256 + $urandom % 256),
                   wdata: $urandom};
    if (rd_sec >= 0)
      dev_rd[rd_sec] = !out_empty[rd_sec] && ($urandom % 4 != 0);
  endtask

  task automatic wait_done(input string what);
    int c;
    c = 0;
    do
    begin
      next_cycle();
      c++;
    end
    while (!done && c < op_limit);
    if (!done)
      check_inst.report_failure($sformatf("%s transfer never signalled done", what));
  endtask

  task automatic run_fill(input int s);
    int n;
    int lim;
    int count;
    addr_t addr;
    n = $urandom_range(20, 1);
    for (int i = 0; i < n; i++)
    begin
      next_cycle();
      dev_wr[s]   = 1'b1;
      dev_data[s] = $urandom;
      dev_mark[s] = ($urandom % 8 == 0);
    end
    lim   = (n < 16) ? n : 16;
    count = $urandom_range(lim, 0);
    addr  = addr_t'($urandom % 112);
    next_cycle();
    cmd_valid = 1'b1;
    cmd = '{dir: 1'b0, section: section_t'(s), addr: addr, count: count_t'(count)};
    wait_done("fill");
    for (int i = 0; i < count; i++)               // Read back the written range
    begin
      next_cycle();
      host_req = '{req: 1'b1, we: 1'b0, addr: addr_t'(addr + i), wdata: '0};
    end
    repeat (2) next_cycle();
  endtask

  task automatic run_empty(input int s);
    int c;
    next_cycle();
    rd_sec    = s;
    cmd_valid = 1'b1;
    cmd = '{dir: 1'b1, section: section_t'(s), addr: addr_t'($urandom % 88),
            count: count_t'($urandom_range(40, 0))};
    wait_done("empty");
    c = 0;
    while (!out_empty[s] && c < op_limit)
    begin
      next_cycle();
      c++;
    end
    rd_sec = -1;
    next_cycle();
    check_inst.check_drained(s);
  endtask

  // Run limit
  initial
  begin
    #(wd_ns);
    $display("watchdog expired after %0d ns, the run is stuck", wd_ns);
    $display("Simulation failed");
    $finish;
  end

  initial
  begin
    void'($urandom(32'h820f_8c53));
    RST_MASTER = 1'b1;
    contention = 1'b0;
    rd_sec     = -1;
    dev_wr     = '0;
    dev_mark   = '0;
    dev_rd     = '0;
    cmd_valid  = 1'b0;
    cmd        = '0;
    host_req   = '0;
    for (int s = 0; s < `SNOW_SECTIONS; s++)
      dev_data[s] = '0;
    repeat (10) @(negedge CLK_n);
    RST_MASTER = 1'b0;
    repeat (3) next_cycle();
    check_inst.end_test("reset");

    for (int i = 0; i < n_host; i++)
    begin
      next_cycle();
      if ($urandom % 4 != 0)
        host_req = '{req: 1'b1, we: 1'($urandom % 2), addr: addr_t'($urandom), wdata: $urandom};
    end
    for (int a = 0; a < 128; a++)                 // Mover region gets known contents
    begin
      next_cycle();
      host_req = '{req: 1'b1, we: 1'b1, addr: addr_t'(a), wdata: $urandom};
    end
    repeat (2) next_cycle();
    check_inst.end_test("host");

    for (int i = 0; i < n_fill; i++)
      run_fill($urandom % 4);
    check_inst.end_test("fill");

    for (int i = 0; i < n_empty; i++)
      run_empty($urandom % 4);
    check_inst.end_test("empty");

    contention = 1'b1;
    for (int i = 0; i < n_mixed; i++)
    begin
      if ($urandom % 2 == 0)
        run_fill($urandom % 4);
      else
        run_empty($urandom % 4);
    end
    contention = 1'b0;
    repeat (3) next_cycle();
    check_inst.end_test("contention");

    check_inst.summary();
    if (check_inst.errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+.
snow_pkg.sv
section_buffer.sv
shared_memory.sv
fill_mover.sv
empty_mover.sv
snow_core.sv
snow_checker.sv
tb_snow_core.sv

/* Makefile */
# Verilator flow for the snow_core testbench

VERILATOR ?= verilator
TOP       ?= tb_snow_core
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing -Wno-fatal
LINTFLAGS ?= --timing
PASS_MSG  ?= Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$($(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
